// File: src.f
rtl/OramPkg.sv
rtl/OramDramIf.sv
rtl/BackendCtrl.sv
rtl/Stash.sv
rtl/PathReader.sv
rtl/PathWriter.sv
rtl/DramArbiter.sv
rtl/PathOramBackend.sv
verif/OramTb.sv

// File: run.sh
#!/bin/sh
# Build the ORAM backend testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module OramTb -f src.f -o simv \
	|| { echo "compile failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

// File: verif/OramTb.sv
// --------------------------------------------------------------------------
// Testbench for the Path ORAM backend: credit based DRAM model, random
// frontend traffic, reference memory, path and load checks
// --------------------------------------------------------------------------
module OramTb import OramPkg::*; ();

	localparam int ClockPeriod = 40;
	localparam int NumCmds = 40;
	localparam int MaxWait = 200;
	localparam int DramCredits = 4;
	localparam logic [SlotWidth-1:0] CipherKey = 44'h5A3C96E1B27;

	typedef struct {
		logic write;
		logic [SlotWidth-1:0] data;
		int due;
	} pending_t;

	logic Clock, rstN;
	cmd_e command;
	logic [AddrWidth-1:0] pAddr;
	leaf_t currentLeaf, remappedLeaf;
	logic [DataWidth-1:0] storeData, loadData;
	logic commandValid, commandReady, loadValid, loadReady;
	logic dramCmdValid, dramCmdWrite, dramCredit, dramReadValid;
	dramAddr_t dramCmdAddr;
	logic [SlotWidth-1:0] dramCmdData, dramReadData;

	// Reference state and model storage
	logic [31:0] rngState = 32'h86eb;
	logic [DataWidth-1:0] refMem [256];
	logic refWritten [256];
	leaf_t posMap [256];
	logic [SlotWidth-1:0] dramMem [32];
	pending_t pending [$];
	logic [DataWidth-1:0] expLoads [$];
	leaf_t pathLeafExp;
	logic withhold = 1'b0;
	int beat = 0;
	int outstanding = 0;
	logic heldValid = 1'b0;
	logic [DataWidth-1:0] heldData, expData;

	PathOramBackend #(.DramCredits(DramCredits), .CipherKey(CipherKey)) UUT (.*);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	// --------------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawRand(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	// Expected load: last stored data, zero if never written
	function automatic logic [DataWidth-1:0] refLoad(input logic [AddrWidth-1:0] addr);
		return refWritten[addr] ? refMem[addr] : '0;
	endfunction

	// Bucket in heap order (root 0) times Z plus slot number
	function automatic dramAddr_t pathSlot(input leaf_t leaf, input int level,
			input int slotNum);
		int bucket;
		bucket = (1 << level) - 1 + (int'(leaf) >> (OramL - level));
		return dramAddr_t'(bucket * OramZ + slotNum);
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkData(input logic [DataWidth-1:0] got,
			input logic [DataWidth-1:0] exp, input string what);
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	task automatic checkAddr(input dramAddr_t got, input dramAddr_t exp, input string what);
		if (got !== exp)
			failRun($sformatf("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic checkCount(input int got, input int limit, input string what);
		if (got > limit)
			failRun($sformatf("mismatch at %0t: %s, %0d above %0d", $time, what, got, limit));
	endtask

	// One DRAM command: path order, then the decrypted contents of writes
	task automatic checkBeat(input logic isWrite, input dramAddr_t addr,
			input logic [SlotWidth-1:0] data);
		int idx;
		int level;
		dramWord_u plain;
		idx = beat % (2 * PathSlots);
		if (idx < PathSlots) begin
			if (isWrite)
				failRun("a DRAM write was issued during the read phase");
			level = idx / OramZ;
		end else begin
			if (!isWrite)
				failRun("a DRAM read was issued during the write phase");
			level = OramL - (idx - PathSlots) / OramZ;
		end
		checkAddr(addr, pathSlot(pathLeafExp, level, idx % OramZ),
			$sformatf("slot address of beat %0d in command %0d", idx, beat / 16));
		if (isWrite) begin
			plain.raw = data ^ keystream(addr, CipherKey);
			if (!plain.slot.valid && plain.raw != '0)
				failRun("an invalid slot was written with nonzero contents");
			if (plain.slot.valid) begin
				if ((int'(plain.slot.leaf) >> (OramL - level)) !=
						(int'(pathLeafExp) >> (OramL - level)))
					failRun("a written block has a leaf off the written path");
				checkData(plain.slot.data, refLoad(plain.slot.addr), "data of evicted block");
			end
		end
		beat++;
	endtask

	task automatic waitReady();
		int waited;
		waited = 0;
		@(negedge Clock);
		while (!commandReady) begin
			waited++;
			if (waited > MaxWait)
				failRun("timed out waiting for commandReady");
			@(negedge Clock);
		end
	endtask

	task automatic waitLoad();
		int waited;
		waited = 0;
		@(negedge Clock);
		while (!loadValid) begin
			waited++;
			if (waited > MaxWait)
				failRun("timed out waiting for loadValid");
			@(negedge Clock);
		end
	endtask

	// --------------------------------------------------------------------------
	// DRAM model, in order completion after 1 to 4 cycles
	// --------------------------------------------------------------------------
	initial begin : dramModel
		pending_t entry;
		int cycle;
		int delay;
		logic [31:0] r;
		logic giveCredit, giveRead;
		logic [SlotWidth-1:0] readWord;
		cycle = 0;
		for (int a = 0; a < 32; a++)
			dramMem[a] = keystream(dramAddr_t'(a), CipherKey);
		forever begin
			@(negedge Clock);
			cycle++;
			if (rstN && dramCmdValid) begin
				outstanding++;
				checkCount(outstanding, DramCredits, "outstanding DRAM commands");
				checkBeat(dramCmdWrite, dramCmdAddr, dramCmdData);
				drawRand(r);
				// Long stalls hold credits back
				delay = 1 + int'(r[1:0]) + (withhold ? 16 : 0);
				entry.write = dramCmdWrite;
				entry.data = dramMem[dramCmdAddr];
				entry.due = cycle + delay;
				if (dramCmdWrite)
					dramMem[dramCmdAddr] = dramCmdData;
				pending.push_back(entry);
			end
			// Credit on the pins now reaches the DUT at the next edge
			if (dramCredit)
				outstanding--;
			giveCredit = 1'b0;
			giveRead = 1'b0;
			readWord = '0;
			if (pending.size() > 0 && pending[0].due <= cycle) begin
				entry = pending.pop_front();
				giveCredit = 1'b1;
				giveRead = !entry.write;
				readWord = entry.write ? '0 : entry.data;
			end
			@(posedge Clock);
			#2;
			dramCredit = giveCredit;
			dramReadValid = giveRead;
			dramReadData = readWord;
		end
	end

	// --------------------------------------------------------------------------
	// Load compare and back-pressure checks
	// --------------------------------------------------------------------------
	always @(negedge Clock) begin
		if (rstN) begin
			if (heldValid) begin
				if (!loadValid)
					failRun("loadValid dropped while loadReady was low");
				checkData(loadData, heldData, "loadData under back-pressure");
			end
			if (loadValid && commandReady)
				failRun("commandReady was high while a load was pending");
			if (loadValid && loadReady) begin
				if (expLoads.size() == 0)
					failRun("a load was returned with no read command pending");
				expData = expLoads.pop_front();
				checkData(loadData, expData, "load result");
			end
			heldValid = loadValid && !loadReady;
			heldData = loadData;
		end
	end

	initial begin : watchdog
		#(NumCmds * MaxWait * ClockPeriod);
		failRun("watchdog expired before the command sequence finished");
	end

	// --------------------------------------------------------------------------
	// Frontend driver
	// --------------------------------------------------------------------------
	initial begin : driver
		logic [31:0] r;
		logic [AddrWidth-1:0] addrPool [6];
		logic holdLoad;
		addrPool = '{8'h03, 8'h17, 8'h2a, 8'h40, 8'h9c, 8'hf1};
		rstN = 1'b0;
		command = CmdRead;
		pAddr = '0;
		currentLeaf = '0;
		remappedLeaf = '0;
		storeData = '0;
		commandValid = 1'b0;
		loadReady = 1'b1;
		dramCredit = 1'b0;
		dramReadValid = 1'b0;
		dramReadData = '0;
		pathLeafExp = '0;
		for (int i = 0; i < 256; i++) begin
			refMem[i] = '0;
			refWritten[i] = 1'b0;
			posMap[i] = '0;
		end
		for (int i = 0; i < 6; i++) begin
			drawRand(r);
			posMap[addrPool[i]] = leaf_t'(r[2:0]);
		end
		repeat (2) @(posedge Clock);
		#2;
		rstN = 1'b1;
		@(negedge Clock);
		if (commandReady !== 1'b1 || loadValid !== 1'b0 || dramCmdValid !== 1'b0)
			failRun("after reset commandReady is not 1 or loadValid or dramCmdValid is not 0");

		for (int n = 0; n < NumCmds; n++) begin
			waitReady();
			@(posedge Clock);
			#2;
			drawRand(r);
			pAddr = addrPool[r % 6];
			drawRand(r);
			command = r[7] ? CmdWrite : CmdRead;
			drawRand(r);
			storeData = r;
			drawRand(r);
			remappedLeaf = leaf_t'(r[2:0]);
			currentLeaf = posMap[pAddr];
			posMap[pAddr] = remappedLeaf;
			pathLeafExp = currentLeaf;
			withhold = (n % 5 == 2);
			holdLoad = (command == CmdRead) && (n % 3 == 1);
			loadReady = !holdLoad;
			if (command == CmdWrite) begin
				refMem[pAddr] = storeData;
				refWritten[pAddr] = 1'b1;
			end else
				expLoads.push_back(refLoad(pAddr));
			commandValid = 1'b1;
			@(posedge Clock);
			#2;
			commandValid = 1'b0;
			// Keep the load waiting a few cycles
			if (holdLoad) begin
				waitLoad();
				repeat (6) @(posedge Clock);
				#2;
				loadReady = 1'b1;
			end
		end
		waitReady();
		checkCount(expLoads.size(), 0, "loads still missing at the end");
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: rtl/PathOramBackend.sv
// --------------------------------------------------------------------------
// Path ORAM backend: command sequencer, stash, two path engines and the
// credit based DRAM arbiter
// --------------------------------------------------------------------------
module PathOramBackend import OramPkg::*; #(
	parameter int StashSize = 12,
	parameter int DramCredits = 4,
	parameter logic [SlotWidth-1:0] CipherKey = 44'h5A3C96E1B27
) (
	input logic Clock,
	input logic rstN,

	// Frontend
	input cmd_e command,
	input logic [AddrWidth-1:0] pAddr,
	input leaf_t currentLeaf,
	input leaf_t remappedLeaf,
	input logic [DataWidth-1:0] storeData,
	input logic commandValid,
	output logic commandReady,
	output logic [DataWidth-1:0] loadData,
	output logic loadValid,
	input logic loadReady,

	// DRAM
	output logic dramCmdValid,
	output logic dramCmdWrite,
	output dramAddr_t dramCmdAddr,
	output logic [SlotWidth-1:0] dramCmdData,
	input logic dramCredit,
	input logic dramReadValid,
	input logic [SlotWidth-1:0] dramReadData
);

	// --------------------------------------------------------------------------
	// Internal wires
	// --------------------------------------------------------------------------
	logic readStart, readDone, writeStart, writeDone;
	leaf_t pathLeaf;

	logic insValid;
	slot_t insSlot;

	logic accessValid, accessWrite, accessFound;
	logic [AddrWidth-1:0] accessAddr;
	logic [DataWidth-1:0] accessData, accessOldData;
	leaf_t accessLeaf;

	level_t evictLevel;
	leaf_t evictLeaf;
	logic evictTake, evictValid;
	slot_t evictSlot;

	OramDramIf readLink ();
	OramDramIf writeLink ();

	// --------------------------------------------------------------------------
	// Instances
	// --------------------------------------------------------------------------
	BackendCtrl ctrl (
		.Clock, .rstN,
		.command, .pAddr, .currentLeaf, .remappedLeaf, .storeData,
		.commandValid, .commandReady,
		.loadData, .loadValid, .loadReady,
		.readStart, .readDone, .writeStart, .writeDone, .pathLeaf,
		.accessValid, .accessWrite, .accessAddr, .accessData, .accessLeaf,
		.accessFound, .accessOldData
	);

	Stash #(.StashSize(StashSize)) stash (
		.Clock, .rstN,
		.insValid, .insSlot,
		.accessValid, .accessWrite, .accessAddr, .accessData, .accessLeaf,
		.accessFound, .accessOldData,
		.evictLevel, .evictLeaf, .evictTake, .evictValid, .evictSlot
	);

	PathReader #(.CipherKey(CipherKey)) reader (
		.Clock, .rstN,
		.readStart, .pathLeaf, .readDone,
		.insValid, .insSlot,
		.dram(readLink.peer)
	);

	PathWriter #(.CipherKey(CipherKey)) writer (
		.Clock, .rstN,
		.writeStart, .pathLeaf, .writeDone,
		.evictLevel, .evictLeaf, .evictTake, .evictValid, .evictSlot,
		.dram(writeLink.peer)
	);

	DramArbiter #(.DramCredits(DramCredits)) arbiter (
		.Clock, .rstN,
		.readPort(readLink.arbiter),
		.writePort(writeLink.arbiter),
		.dramCmdValid, .dramCmdWrite, .dramCmdAddr, .dramCmdData,
		.dramCredit, .dramReadValid, .dramReadData
	);

endmodule

// File: rtl/DramArbiter.sv
// --------------------------------------------------------------------------
// DRAM arbiter: shares the DRAM port between the engines under credits
// --------------------------------------------------------------------------
module DramArbiter import OramPkg::*; #(
	parameter int DramCredits = 4
) (
	input logic Clock,
	input logic rstN,
	OramDramIf.arbiter readPort,
	OramDramIf.arbiter writePort,
	output logic dramCmdValid,
	output logic dramCmdWrite,
	output dramAddr_t dramCmdAddr,
	output logic [SlotWidth-1:0] dramCmdData,
	input logic dramCredit,
	input logic dramReadValid,
	input logic [SlotWidth-1:0] dramReadData
);

	localparam int CreditWidth = $clog2(DramCredits + 1);

	logic [CreditWidth-1:0] credits;
	logic haveCredit;
	dramWord_u readWord;

	// Writer first when both ask
	assign haveCredit = (credits != '0);
	assign writePort.grant = haveCredit && writePort.req;
	assign readPort.grant = haveCredit && readPort.req && !writePort.req;

	assign dramCmdValid = readPort.grant || writePort.grant;
	assign dramCmdWrite = writePort.grant ? writePort.write : readPort.write;
	assign dramCmdAddr = writePort.grant ? writePort.addr : readPort.addr;
	assign dramCmdData = writePort.grant ? writePort.wdata.raw : readPort.wdata.raw;

	// Read data belongs to the reader only
	assign readWord.raw = dramReadData;
	assign readPort.rdValid = dramReadValid;
	assign readPort.rdData = readWord;
	assign writePort.rdValid = 1'b0;
	assign writePort.rdData = '0;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			credits <= CreditWidth'(DramCredits);
		else begin
			case ({dramCmdValid, dramCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: rtl/PathWriter.sv
// --------------------------------------------------------------------------
// Path writer: pulls stash blocks leaf to root, encrypts, writes slots
// --------------------------------------------------------------------------
module PathWriter import OramPkg::*; #(
	parameter logic [SlotWidth-1:0] CipherKey = '0
) (
	input logic Clock,
	input logic rstN,
	input logic writeStart,
	input leaf_t pathLeaf,
	output logic writeDone,
	output level_t evictLevel,
	output leaf_t evictLeaf,
	output logic evictTake,
	input logic evictValid,
	input slot_t evictSlot,
	OramDramIf.peer dram
);

	logic busy;
	leaf_t leaf;
	logic [2:0] slotCount;
	logic lastSlot;
	slot_t outSlot;
	dramWord_u plainWord, cipherWord;

	// Leaf level first, root last
	assign evictLevel = level_t'(OramL - int'(slotCount) / OramZ);
	assign evictLeaf = leaf;
	assign lastSlot = (slotCount == 3'(PathSlots - 1));

	// Offer stays put while waiting, the stash only changes on a take
	assign outSlot = evictValid ? evictSlot : '0;
	assign plainWord.slot = outSlot;
	assign cipherWord.raw = plainWord.raw ^ keystream(dram.addr, CipherKey);

	assign dram.req = busy;
	assign dram.write = 1'b1;
	assign dram.addr = slotAddr(leaf, evictLevel, int'(slotCount) % OramZ);
	assign dram.wdata = cipherWord;
	assign evictTake = busy && dram.grant && evictValid;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			slotCount <= '0;
			writeDone <= 1'b0;
		end else begin
			writeDone <= busy && dram.grant && lastSlot;
			if (writeStart) begin
				busy <= 1'b1;
				slotCount <= '0;
			end else if (busy && dram.grant) begin
				slotCount <= slotCount + 3'd1;
				if (lastSlot)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (writeStart)
			leaf <= pathLeaf;
	end

endmodule

// File: rtl/PathReader.sv
// --------------------------------------------------------------------------
// Path reader: slot reads root to leaf, decrypt, insert real blocks
// --------------------------------------------------------------------------
module PathReader import OramPkg::*; #(
	parameter logic [SlotWidth-1:0] CipherKey = '0
) (
	input logic Clock,
	input logic rstN,
	input logic readStart,
	input leaf_t pathLeaf,
	output logic readDone,
	output logic insValid,
	output slot_t insSlot,
	OramDramIf.peer dram
);

	logic busy;
	leaf_t leaf;
	logic [3:0] reqCount, rspCount;
	dramAddr_t addrFifo [PathSlots];
	dramWord_u plainWord;

	// Requests and responses counted apart so reads overlap
	assign dram.req = busy && (reqCount < 4'(PathSlots));
	assign dram.write = 1'b0;
	assign dram.wdata = '0;
	assign dram.addr = slotAddr(leaf, level_t'(reqCount / OramZ), int'(reqCount % OramZ));

	// Responses return in order
	assign plainWord.raw = dram.rdData.raw ^ keystream(addrFifo[rspCount[2:0]], CipherKey);
	assign insSlot = plainWord.slot;
	assign insValid = busy && dram.rdValid && plainWord.slot.valid;
	assign readDone = busy && dram.rdValid && (rspCount == 4'(PathSlots - 1));

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			reqCount <= '0;
			rspCount <= '0;
		end else if (readStart) begin
			busy <= 1'b1;
			reqCount <= '0;
			rspCount <= '0;
		end else begin
			if (dram.req && dram.grant)
				reqCount <= reqCount + 4'd1;
			if (busy && dram.rdValid)
				rspCount <= rspCount + 4'd1;
			if (readDone)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (readStart)
			leaf <= pathLeaf;
		if (dram.req && dram.grant)
			addrFifo[reqCount[2:0]] <= dram.addr;
	end

endmodule

// File: rtl/Stash.sv
// --------------------------------------------------------------------------
// Stash holding path blocks with insert, address lookup and update, and
// deepest-fit eviction
// --------------------------------------------------------------------------
module Stash import OramPkg::*; #(
	parameter int StashSize = 12
) (
	input logic Clock,
	input logic rstN,
	input logic insValid,
	input slot_t insSlot,
	input logic accessValid,
	input logic accessWrite,
	input logic [AddrWidth-1:0] accessAddr,
	input logic [DataWidth-1:0] accessData,
	input leaf_t accessLeaf,
	output logic accessFound,
	output logic [DataWidth-1:0] accessOldData,
	input level_t evictLevel,
	input leaf_t evictLeaf,
	input logic evictTake,
	output logic evictValid,
	output slot_t evictSlot
);

	localparam int IdxWidth = $clog2(StashSize);

	slot_t entries [StashSize];
	logic [StashSize-1:0] used;

	logic freeFound, hitFound;
	logic [IdxWidth-1:0] freeIdx, hitIdx, evictIdx;

	// --------------------------------------------------------------------------
	// Priority search with the lowest index winning
	// --------------------------------------------------------------------------
	always_comb begin
		int shift;
		shift = OramL - int'(evictLevel);
		freeFound = 1'b0;
		freeIdx = '0;
		hitFound = 1'b0;
		hitIdx = '0;
		evictValid = 1'b0;
		evictIdx = '0;
		for (int i = StashSize - 1; i >= 0; i--) begin
			if (!used[i]) begin
				freeFound = 1'b1;
				freeIdx = IdxWidth'(i);
			end
			if (used[i] && entries[i].addr == accessAddr) begin
				hitFound = 1'b1;
				hitIdx = IdxWidth'(i);
			end
			// Leaf shares the path down to the bucket level
			if (used[i] && (entries[i].leaf >> shift) == (evictLeaf >> shift)) begin
				evictValid = 1'b1;
				evictIdx = IdxWidth'(i);
			end
		end
	end

	assign evictSlot = entries[evictIdx];

	// --------------------------------------------------------------------------
	// Occupancy and access result
	// --------------------------------------------------------------------------
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			used <= '0;
			accessFound <= 1'b0;
			accessOldData <= '0;
		end else begin
			if (insValid && freeFound)
				used[freeIdx] <= 1'b1;
			if (evictTake && evictValid)
				used[evictIdx] <= 1'b0;
			if (accessValid) begin
				accessFound <= hitFound;
				accessOldData <= entries[hitIdx].data;
				if (!hitFound && accessWrite && freeFound)
					used[freeIdx] <= 1'b1;
			end
		end
	end

	// Block contents
	always_ff @(posedge Clock) begin
		if (insValid && freeFound)
			entries[freeIdx] <= insSlot;
		if (accessValid) begin
			if (hitFound) begin
				entries[hitIdx].leaf <= accessLeaf;
				if (accessWrite)
					entries[hitIdx].data <= accessData;
			end else if (accessWrite && freeFound) begin
				entries[freeIdx] <= '{valid: 1'b1, addr: accessAddr,
					leaf: accessLeaf, data: accessData};
			end
		end
	end

endmodule

// File: rtl/BackendCtrl.sv
// --------------------------------------------------------------------------
// Command sequencer: read path, stash access, write path, load response
// --------------------------------------------------------------------------
module BackendCtrl import OramPkg::*; (
	input logic Clock,
	input logic rstN,
	input cmd_e command,
	input logic [AddrWidth-1:0] pAddr,
	input leaf_t currentLeaf,
	input leaf_t remappedLeaf,
	input logic [DataWidth-1:0] storeData,
	input logic commandValid,
	output logic commandReady,
	output logic [DataWidth-1:0] loadData,
	output logic loadValid,
	input logic loadReady,
	output logic readStart,
	input logic readDone,
	output logic writeStart,
	input logic writeDone,
	output leaf_t pathLeaf,
	output logic accessValid,
	output logic accessWrite,
	output logic [AddrWidth-1:0] accessAddr,
	output logic [DataWidth-1:0] accessData,
	output leaf_t accessLeaf,
	input logic accessFound,
	input logic [DataWidth-1:0] accessOldData
);

	typedef enum logic [2:0] {Idle, Read, Access, Write, Respond} ctrlState_e;

	ctrlState_e state;
	logic accessStep;

	// Registered command
	cmd_e cmdReg;
	logic [AddrWidth-1:0] addrReg;
	leaf_t leafReg, remapReg;
	logic [DataWidth-1:0] dataReg;

	assign commandReady = (state == Idle);
	assign loadValid = (state == Respond);
	assign pathLeaf = leafReg;

	// Stash access takes two cycles, request then capture
	assign accessValid = (state == Access) && !accessStep;
	assign accessWrite = (cmdReg == CmdWrite);
	assign accessAddr = addrReg;
	assign accessData = dataReg;
	assign accessLeaf = remapReg;
	assign writeStart = (state == Access) && accessStep;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
			accessStep <= 1'b0;
			readStart <= 1'b0;
		end else begin
			readStart <= 1'b0;
			case (state)
				Idle: if (commandValid) begin
					readStart <= 1'b1;
					state <= Read;
				end
				Read: if (readDone) begin
					accessStep <= 1'b0;
					state <= Access;
				end
				Access: begin
					accessStep <= 1'b1;
					if (accessStep)
						state <= Write;
				end
				Write: if (writeDone)
					state <= (cmdReg == CmdRead) ? Respond : Idle;
				Respond: if (loadReady)
					state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (commandReady && commandValid) begin
			cmdReg <= command;
			addrReg <= pAddr;
			leafReg <= currentLeaf;
			remapReg <= remappedLeaf;
			dataReg <= storeData;
		end
		// Unwritten blocks read as zero
		if (writeStart)
			loadData <= accessFound ? accessOldData : '0;
	end

endmodule

// File: rtl/OramDramIf.sv
// --------------------------------------------------------------------------
// Link between one path engine and the DRAM arbiter
// --------------------------------------------------------------------------
interface OramDramIf import OramPkg::*; ();

	// Request side, held until granted
	logic req;
	logic write;
	dramAddr_t addr;
	dramWord_u wdata;

	// Arbiter side
	logic grant;
	logic rdValid;
	dramWord_u rdData;

	modport peer (
		output req, write, addr, wdata,
		input grant, rdValid, rdData
	);

	modport arbiter (
		input req, write, addr, wdata,
		output grant, rdValid, rdData
	);

endinterface

// File: rtl/OramPkg.sv
// --------------------------------------------------------------------------
// ORAM package: tree sizes, command and slot types, DRAM word view, and the
// keystream used to scramble slots on their way to and from DRAM
// --------------------------------------------------------------------------
package OramPkg;

	// Tree shape
	localparam int OramL = 3;
	localparam int OramZ = 2;
	localparam int AddrWidth = 8;
	localparam int DataWidth = 32;

	localparam int LevelWidth = $clog2(OramL + 1);
	localparam int PathSlots = (OramL + 1) * OramZ;
	localparam int SlotWidth = 1 + AddrWidth + OramL + DataWidth;

	typedef logic [OramL-1:0] leaf_t;
	typedef logic [LevelWidth-1:0] level_t;
	typedef logic [4:0] dramAddr_t;

	typedef enum logic {
		CmdRead = 1'b0,
		CmdWrite = 1'b1
	} cmd_e;

	typedef struct packed {
		logic valid;
		logic [AddrWidth-1:0] addr;
		leaf_t leaf;
		logic [DataWidth-1:0] data;
	} slot_t;

	// Same DRAM word seen as a slot or as cipher bits
	typedef union packed {
		slot_t slot;
		logic [SlotWidth-1:0] raw;
	} dramWord_u;

	// Heap order bucket (root 0) times Z plus the slot in the bucket
	function automatic dramAddr_t slotAddr(leaf_t leaf, level_t level, int slotNum);
		int bucket;
		bucket = (1 << level) - 1 + int'(leaf >> (OramL - int'(level)));
		return dramAddr_t'(bucket * OramZ + slotNum);
	endfunction

	// Stand-in for AES, only keeps plaintext off the pins
	function automatic logic [SlotWidth-1:0] keystream(dramAddr_t addr,
			logic [SlotWidth-1:0] key);
		logic [SlotWidth-1:0] spread;
		spread = {addr[3:0], {8{addr}}};
		return key ^ (spread * 44'd2654435761);
	endfunction

endpackage
